// File: rtl/wb_macros.svh
`ifndef WB_MACROS_SVH
`define WB_MACROS_SVH

// Image size in pixels, fixed at build time
`define WB_IMG_W 16
`define WB_IMG_H 12

// Edge of the square window
// The line buffer keeps one row memory fewer than this
`define WB_WIN 9

// Bits per pixel
`define WB_PIX_W 8

`endif

// File: rtl/wb_pkg.sv
`include "wb_macros.svh"

package wb_pkg;

    typedef logic [`WB_PIX_W-1:0] pixel_t;

    // Element 0 is the oldest image row, the top-most element is the newest
    typedef pixel_t [`WB_WIN-1:0] column_t;

    // Element 0 is the leftmost column of the window
    typedef column_t [`WB_WIN-1:0] window_t;

    typedef logic [$clog2(`WB_IMG_H)-1:0] row_t;
    typedef logic [$clog2(`WB_IMG_W)-1:0] col_t;

    typedef enum logic [2:0] {
        st_idle       = 3'b000,
        st_start      = 3'b001,
        st_start_col  = 3'b010,
        st_col_out    = 3'b011,
        st_end_col    = 3'b100,
        st_end_col_2  = 3'b101,
        st_finish_all = 3'b110,
        st_done       = 3'b111
    } ctrl_state_t;

endpackage

// File: rtl/wb_ifaces.sv
`timescale 1ns/1ps

// Scan position of the next pixel to be accepted, plus its flags
interface scan_if;
    import wb_pkg::*;

    row_t row;
    col_t col;
    logic row_eq_max;
    logic col_eq_max;
    logic col_ge_threshold;
    logic count_en;

    modport counter (
        output row,
        output col,
        output row_eq_max,
        output col_eq_max,
        output col_ge_threshold,
        input  count_en
    );

    modport ctrl (
        input  row_eq_max,
        input  col_eq_max,
        input  col_ge_threshold,
        output count_en
    );

endinterface

// One image column on its way from the line buffer into the window
interface column_if;
    import wb_pkg::*;

    column_t column;
    logic    shift;

    modport producer (output column, input shift);
    modport ctrl     (output shift);
    modport consumer (input column, input shift);

endinterface

// File: rtl/scan_counter.sv
`timescale 1ns/1ps
`include "wb_macros.svh"

module scan_counter (
    input logic     clk,
    input logic     rst_n,
    input logic     start,
    input logic     shift,
    scan_if.counter scan
);
    import wb_pkg::*;

    row_t row_q;
    col_t col_q;
    logic step;
    logic at_last_col;
    logic at_last_row;

    assign step        = shift && scan.count_en;
    assign at_last_col = (col_q == col_t'(`WB_IMG_W - 1));
    assign at_last_row = (row_q == row_t'(`WB_IMG_H - 1));

    // Position of the pixel that the next input transfer will carry
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_q <= '0;
            col_q <= '0;
        end else if (start) begin
            row_q <= '0;
            col_q <= '0;
        end else if (step) begin
            if (at_last_col) begin
                col_q <= '0;
                // The last pixel of a frame wraps back to the origin
                if (at_last_row) begin
                    row_q <= '0;
                end else begin
                    row_q <= row_q + 1'b1;
                end
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    assign scan.row        = row_q;
    assign scan.col        = col_q;
    assign scan.row_eq_max = at_last_row;
    assign scan.col_eq_max = at_last_col;

    // A window is complete once eight rows and eight columns lie above and left
    assign scan.col_ge_threshold = (row_q >= row_t'(`WB_WIN - 1)) &&
                                   (col_q >= col_t'(`WB_WIN - 1));

endmodule

// File: rtl/window_ctrl.sv
`timescale 1ns/1ps

module window_ctrl (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    input  logic  in_valid,
    input  logic  win_valid,
    input  logic  win_ready,
    output logic  in_ready,
    output logic  frame_done,
    scan_if.ctrl  scan,
    column_if.ctrl col
);
    import wb_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        slot_free;
    logic        accept_state;
    logic        shift;
    logic        row_done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // The window array may move only when its content is gone or leaving now
    assign slot_free    = !win_valid || win_ready;
    assign accept_state = (state == st_start_col) || (state == st_col_out);
    assign in_ready     = accept_state && slot_free;
    assign shift        = in_valid && in_ready;

    assign col.shift     = shift;
    assign scan.count_en = accept_state;

    // Last pixel of a row that emits windows is taken in this cycle
    assign row_done = shift && scan.col_eq_max && scan.col_ge_threshold;

    // Pulses once the final window of the frame has been taken
    assign frame_done = (state == st_finish_all) && !win_valid;

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (start) begin
                    next_state = st_start;
                end
            end
            st_start: next_state = st_start_col;
            st_start_col: begin
                if (row_done) begin
                    next_state = scan.row_eq_max ? st_finish_all : st_end_col;
                end else if (scan.col_ge_threshold) begin
                    next_state = st_col_out;
                end
            end
            st_col_out: begin
                if (row_done) begin
                    next_state = scan.row_eq_max ? st_finish_all : st_end_col;
                end
            end
            st_end_col:   next_state = st_end_col_2;
            st_end_col_2: next_state = st_start_col;
            st_finish_all: begin
                if (!win_valid) begin
                    next_state = st_done;
                end
            end
            st_done: next_state = st_idle;
            default: next_state = st_idle;
        endcase
    end

endmodule

// File: rtl/line_buffer.sv
`timescale 1ns/1ps
`include "wb_macros.svh"

module line_buffer (
    input logic            clk,
    input logic            rst_n,
    input wb_pkg::pixel_t  in_pixel,
    input wb_pkg::col_t    col_idx,
    column_if.producer     col
);
    import wb_pkg::*;

    // Memory 0 holds the row eight above the current one, memory 7 the row just above
    pixel_t  line_mem [`WB_WIN-1][`WB_IMG_W];
    column_t col_word;

    always_comb begin
        for (int k = 0; k < `WB_WIN - 1; k++) begin
            col_word[k] = line_mem[k][col_idx];
        end
        col_word[`WB_WIN-1] = in_pixel;
    end

    assign col.column = col_word;

    // Every stored pixel of this column moves one memory toward the oldest row,
    // and the accepted pixel takes the place of the row just above
    always_ff @(posedge clk) begin
        if (rst_n && col.shift) begin
            for (int k = 0; k < `WB_WIN - 1; k++) begin
                line_mem[k][col_idx] <= col_word[k+1];
            end
        end
    end

endmodule

// File: rtl/window_regs.sv
`timescale 1ns/1ps
`include "wb_macros.svh"

module window_regs (
    input  logic            clk,
    input  logic            rst_n,
    column_if.consumer      col,
    input  logic            win_ready,
    input  logic            emit,
    output logic            win_valid,
    output wb_pkg::window_t win_data
);

    // New column enters on the right, the leftmost one drops out
    always_ff @(posedge clk) begin
        if (col.shift) begin
            win_data <= {col.column, win_data[`WB_WIN-1:1]};
        end
    end

    // Shift is only granted while the slot is free, so a new window never
    // overwrites one that has not left yet
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_valid <= 1'b0;
        end else if (col.shift && emit) begin
            win_valid <= 1'b1;
        end else if (win_ready) begin
            win_valid <= 1'b0;
        end
    end

endmodule

// File: rtl/window_buffer_top.sv
`timescale 1ns/1ps

module window_buffer_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  logic            in_valid,
    output logic            in_ready,
    input  wb_pkg::pixel_t  in_pixel,
    output logic            win_valid,
    input  logic            win_ready,
    output wb_pkg::window_t win_data,
    output logic            frame_done
);

    scan_if   scan_bus ();
    column_if col_bus ();

    scan_counter u_scan_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .shift (col_bus.shift),
        .scan  (scan_bus.counter)
    );

    window_ctrl u_window_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .in_valid   (in_valid),
        .win_valid  (win_valid),
        .win_ready  (win_ready),
        .in_ready   (in_ready),
        .frame_done (frame_done),
        .scan       (scan_bus.ctrl),
        .col        (col_bus.ctrl)
    );

    // The line buffer is addressed by the column of the pixel being accepted
    line_buffer u_line_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_pixel (in_pixel),
        .col_idx  (scan_bus.col),
        .col      (col_bus.producer)
    );

    window_regs u_window_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .col       (col_bus.consumer),
        .win_ready (win_ready),
        .emit      (scan_bus.col_ge_threshold),
        .win_valid (win_valid),
        .win_data  (win_data)
    );

endmodule

// File: bench/wb_checker.sv
`timescale 1ns/1ps

module wb_checker (
    input logic            clk,
    input logic            rst_n,
    input logic            in_ready,
    input logic            win_valid,
    input logic            win_ready,
    input wb_pkg::window_t win_data,
    input logic            frame_done
);

    int unsigned fail_count;

    // Nothing is offered or signalled in the cycle after a reset cycle
    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !in_ready && !win_valid && !frame_done)
        else begin
            fail_count++;
            $error("outputs active right after reset");
        end

    // A stalled window keeps its valid and its data, and blocks new pixels
    window_hold: assert property (@(posedge clk) disable iff (!rst_n)
        win_valid && !win_ready |=> win_valid && $stable(win_data))
        else begin
            fail_count++;
            $error("window changed while stalled");
        end

    input_blocked: assert property (@(posedge clk) disable iff (!rst_n)
        win_valid && !win_ready |-> !in_ready)
        else begin
            fail_count++;
            $error("in_ready high while the window is stalled");
        end

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        frame_done |=> !frame_done)
        else begin
            fail_count++;
            $error("frame_done longer than one cycle");
        end

endmodule

// File: bench/wb_monitor.sv
`timescale 1ns/1ps
`include "wb_macros.svh"

module wb_monitor (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  logic            in_valid,
    input  logic            in_ready,
    input  wb_pkg::pixel_t  in_pixel,
    input  logic            win_valid,
    input  logic            win_ready,
    input  wb_pkg::window_t win_data,
    input  logic            frame_done,
    output int              data_errs,
    output int              proto_errs,
    output int              windows_seen,
    output int              frames_seen
);
    import wb_pkg::*;

    localparam int WINDOWS_PER_FRAME =
        (`WB_IMG_H - `WB_WIN + 1) * (`WB_IMG_W - `WB_WIN + 1);

    pixel_t  image [`WB_IMG_H][`WB_IMG_W];
    window_t expect_q [$];
    int      pos_q [$];
    int      in_row;
    int      in_col;
    int      frame_windows;
    int      turn_cnt;
    logic    turn_emitting;
    logic    frame_over;
    logic    done_q;

    // Column j of the window is image column c-8+j, element k is image row r-8+k
    function automatic window_t expected_window(input int r, input int c);
        window_t w;
        for (int j = 0; j < `WB_WIN; j++) begin
            for (int k = 0; k < `WB_WIN; k++) begin
                w[j][k] = image[r - `WB_WIN + 1 + k][c - `WB_WIN + 1 + j];
            end
        end
        return w;
    endfunction

    task automatic take_window();
        window_t want_w;
        int      pos;
        logic    bad;
        bad = 1'b0;
        windows_seen++;
        frame_windows++;
        if (expect_q.size() == 0) begin
            proto_errs++;
            $display("A window left at %0t although no pixel had completed one", $time);
        end else begin
            want_w = expect_q.pop_front();
            pos = pos_q.pop_front();
            for (int j = 0; j < `WB_WIN; j++) begin
                for (int k = 0; k < `WB_WIN; k++) begin
                    if (!bad && win_data[j][k] !== want_w[j][k]) begin
                        $display("ERR t=%0t win_data[%0d][%0d] (window row %0d col %0d): %s",
                                 $time, j, k, pos / `WB_IMG_W, pos % `WB_IMG_W,
                                 $sformatf("expected %h, got %h", want_w[j][k], win_data[j][k]));
                        bad = 1'b1;
                    end
                end
            end
            if (bad) begin
                data_errs++;
            end
        end
    endtask

    task automatic take_pixel();
        image[in_row][in_col] = in_pixel;
        if (in_row >= `WB_WIN - 1 && in_col >= `WB_WIN - 1) begin
            expect_q.push_back(expected_window(in_row, in_col));
            pos_q.push_back(in_row * `WB_IMG_W + in_col);
        end
        if (in_col == `WB_IMG_W - 1) begin
            if (in_row < `WB_IMG_H - 1) begin
                turn_cnt = 1;
                turn_emitting = (in_row >= `WB_WIN - 1);
            end
            in_col = 0;
            in_row = (in_row == `WB_IMG_H - 1) ? 0 : in_row + 1;
        end else begin
            in_col++;
        end
    endtask

    // Rows that emit windows end with two blocked cycles, then input follows the slot
    task automatic check_turnaround();
        logic want;
        want = !win_valid || win_ready;
        if (turn_cnt > 0) begin
            if (turn_emitting && turn_cnt <= 2) begin
                if (in_ready) begin
                    proto_errs++;
                    $display("ERR t=%0t in_ready: expected 0, got 1 (turnaround cycle %0d)",
                             $time, turn_cnt);
                end
                turn_cnt++;
            end else begin
                if (in_ready !== want) begin
                    proto_errs++;
                    $display("ERR t=%0t in_ready: expected %b, got %b after a row end",
                             $time, want, in_ready);
                end
                turn_cnt = 0;
            end
        end
    endtask

    task automatic check_frame_end();
        if (done_q) begin
            proto_errs++;
            $display("frame_done stayed high for more than one cycle at %0t", $time);
        end else if (frame_over) begin
            proto_errs++;
            $display("A second frame_done came at %0t before the next start", $time);
        end else begin
            if (frame_windows != WINDOWS_PER_FRAME) begin
                proto_errs++;
                $display("ERR t=%0t window count: expected %0d, got %0d",
                         $time, WINDOWS_PER_FRAME, frame_windows);
            end
            if (expect_q.size() != 0 || win_valid) begin
                proto_errs++;
                $display("frame_done came at %0t before the last window was taken", $time);
            end
            frames_seen++;
            frame_over = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            in_row = 0;
            in_col = 0;
            frame_windows = 0;
            turn_cnt = 0;
            turn_emitting = 1'b0;
            frame_over = 1'b0;
            done_q = 1'b0;
            expect_q.delete();
            pos_q.delete();
        end else begin
            if (start) begin
                in_row = 0;
                in_col = 0;
                frame_windows = 0;
                frame_over = 1'b0;
            end
            check_turnaround();
            if (frame_over && in_ready) begin
                proto_errs++;
                $display("in_ready rose at %0t after frame_done and before a new start", $time);
            end
            if (win_valid && win_ready) begin
                take_window();
            end
            if (in_valid && in_ready) begin
                take_pixel();
            end
            if (frame_done) begin
                check_frame_end();
            end
            done_q = frame_done;
        end
    end

endmodule

// File: bench/tb_window_buffer.sv
`timescale 1ns/1ps
`include "wb_macros.svh"

module tb_window_buffer;
    import wb_pkg::*;

    localparam int FRAMES     = 2;
    localparam int WAIT_LIMIT = 400;
    localparam int WINDOWS_PER_FRAME =
        (`WB_IMG_H - `WB_WIN + 1) * (`WB_IMG_W - `WB_WIN + 1);

    logic    clk;
    logic    rst_n;
    logic    start;
    logic    in_valid;
    logic    in_ready;
    pixel_t  in_pixel;
    logic    win_valid;
    logic    win_ready;
    window_t win_data;
    logic    frame_done;
    int      data_errs;
    int      proto_errs;
    int      windows_seen;
    int      frames_seen;
    int      run_errs;
    int      assert_errs;
    logic    timed_out;

    window_buffer_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_pixel   (in_pixel),
        .win_valid  (win_valid),
        .win_ready  (win_ready),
        .win_data   (win_data),
        .frame_done (frame_done)
    );

    wb_monitor mon (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_pixel     (in_pixel),
        .win_valid    (win_valid),
        .win_ready    (win_ready),
        .win_data     (win_data),
        .frame_done   (frame_done),
        .data_errs    (data_errs),
        .proto_errs   (proto_errs),
        .windows_seen (windows_seen),
        .frames_seen  (frames_seen)
    );

    bind window_buffer_top wb_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_ready   (in_ready),
        .win_valid  (win_valid),
        .win_ready  (win_ready),
        .win_data   (win_data),
        .frame_done (frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // The window sink stalls in about one cycle out of four
    initial begin
        win_ready = 1'b0;
        forever begin
            @(negedge clk);
            win_ready = ($urandom % 4) != 0;
        end
    end

    task automatic send_pixel(input int r, input int c);
        int   gap;
        int   waited;
        logic taken;
        gap = (($urandom % 4) == 0) ? (($urandom % 3) + 1) : 0;
        @(negedge clk);
        in_valid = 1'b0;
        repeat (gap) @(negedge clk);
        in_valid = 1'b1;
        in_pixel = pixel_t'($urandom);
        taken = 1'b0;
        waited = 0;
        while (!taken && waited < WAIT_LIMIT) begin
            @(posedge clk);
            taken = in_ready;
            waited++;
        end
        if (!taken) begin
            $display("Timeout: pixel at row %0d col %0d was not taken within %0d cycles",
                     r, c, WAIT_LIMIT);
            run_errs++;
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_frame_done();
        int   waited;
        logic seen;
        @(negedge clk);
        in_valid = 1'b0;
        seen = 1'b0;
        waited = 0;
        while (!seen && waited < WAIT_LIMIT) begin
            @(posedge clk);
            seen = frame_done;
            waited++;
        end
        if (!seen) begin
            $display("Timeout: frame_done did not arrive within %0d cycles", WAIT_LIMIT);
            run_errs++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_frame();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        for (int r = 0; r < `WB_IMG_H && !timed_out; r++) begin
            for (int c = 0; c < `WB_IMG_W && !timed_out; c++) begin
                send_pixel(r, c);
            end
        end
        if (!timed_out) begin
            wait_frame_done();
        end
        // Leave room for the controller to pass through done back to idle
        repeat (3) @(negedge clk);
    endtask

    initial begin
        void'($urandom(98205));
        rst_n = 1'b0;
        start = 1'b0;
        in_valid = 1'b0;
        in_pixel = '0;
        run_errs = 0;
        timed_out = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        for (int f = 0; f < FRAMES && !timed_out; f++) begin
            run_frame();
        end
        repeat (5) @(negedge clk);
        if (!timed_out && windows_seen != FRAMES * WINDOWS_PER_FRAME) begin
            run_errs++;
            $display("ERR t=%0t windows over the run: expected %0d, got %0d",
                     $time, FRAMES * WINDOWS_PER_FRAME, windows_seen);
        end
        if (!timed_out && frames_seen != FRAMES) begin
            run_errs++;
            $display("ERR t=%0t frame_done pulses: expected %0d, got %0d",
                     $time, FRAMES, frames_seen);
        end
        assert_errs = int'(dut.u_checker.fail_count);
        $display("Errors: window data %0d, protocol %0d, assertions %0d, run %0d",
                 data_errs, proto_errs, assert_errs, run_errs);
        if (data_errs + proto_errs + assert_errs + run_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: window_buffer.f
+incdir+rtl
rtl/wb_pkg.sv
rtl/wb_ifaces.sv
rtl/scan_counter.sv
rtl/window_ctrl.sv
rtl/line_buffer.sv
rtl/window_regs.sv
rtl/window_buffer_top.sv
bench/wb_checker.sv
bench/wb_monitor.sv
bench/tb_window_buffer.sv

// File: Makefile
# Verilator build and run of the 9x9 window buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_window_buffer
FILELIST  ?= window_buffer.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
LOG       ?= sim.log
FAIL_MSG  ?= Something failed

SOURCES := $(wildcard rtl/*.sv rtl/*.svh bench/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
